/* run.sh */
#!/usr/bin/env bash
# build and run the CSR register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --top-module tb_csr_regfile \
  -f tb.f --Mdir "$BUILD_DIR" -o sim_csr
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/sim_csr" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  echo "failures found in $LOG"
  exit 1
fi

echo "no failures found in $LOG"
exit 0

/* src/csr_perf_counters.sv */
////////////////////////////////////////
// performance counters
// mcycle, minstret and mhpmcounter3 with
// the mhpmevent3 selector and the
// mcountinhibit control register
////////////////////////////////////////

module csr_perf_counters (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 csr_we_i,
  input  csr_pkg::csr_addr_e   csr_addr_i,
  input  csr_pkg::csr_data_t   csr_wdata_i,
  input  logic                 retire_i,
  input  csr_pkg::hpm_event_t  hpm_event_i,
  output csr_pkg::counter_t    mcycle_o,
  output csr_pkg::counter_t    minstret_o,
  output csr_pkg::counter_t    mhpmcounter3_o,
  output csr_pkg::csr_data_t   mhpmevent3_o,
  output csr_pkg::csr_data_t   mcountinhibit_o
);

  csr_pkg::counter_t   mcycle_q, minstret_q, hpm3_q;
  csr_pkg::hpm_event_t mhpmevent3_q;
  csr_pkg::csr_data_t  mcountinhibit_q;

  logic cy_lo_we, cy_hi_we;
  logic ir_lo_we, ir_hi_we;
  logic hpm_lo_we, hpm_hi_we;
  logic event_we, inhibit_we;
  logic cy_inc, ir_inc, hpm_inc;

  // a half write replaces the increment of that cycle
  function automatic csr_pkg::counter_t next_count(
    input csr_pkg::counter_t  cur,
    input logic               wr_lo,
    input logic               wr_hi,
    input logic               inc,
    input csr_pkg::csr_data_t wdata
  );
    csr_pkg::counter_t nxt;
    nxt = cur;
    if (wr_lo) begin
      nxt[31:0] = wdata;
    end else if (wr_hi) begin
      nxt[63:32] = wdata;
    end else if (inc) begin
      nxt = cur + 64'd1;
    end
    return nxt;
  endfunction

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////
  assign cy_lo_we   = csr_we_i && (csr_addr_i == csr_pkg::CSR_MCYCLE);
  assign cy_hi_we   = csr_we_i && (csr_addr_i == csr_pkg::CSR_MCYCLEH);
  assign ir_lo_we   = csr_we_i && (csr_addr_i == csr_pkg::CSR_MINSTRET);
  assign ir_hi_we   = csr_we_i && (csr_addr_i == csr_pkg::CSR_MINSTRETH);
  assign hpm_lo_we  = csr_we_i && (csr_addr_i == csr_pkg::CSR_MHPMCOUNTER3);
  assign hpm_hi_we  = csr_we_i && (csr_addr_i == csr_pkg::CSR_MHPMCOUNTER3H);
  assign event_we   = csr_we_i && (csr_addr_i == csr_pkg::CSR_MHPMEVENT3);
  assign inhibit_we = csr_we_i && (csr_addr_i == csr_pkg::CSR_MCOUNTINHIBIT);

  // increment qualifiers, selector and inhibit as held this cycle
  assign cy_inc  = !mcountinhibit_q[0];
  assign ir_inc  = !mcountinhibit_q[2] && retire_i;
  assign hpm_inc = !mcountinhibit_q[3] && |(hpm_event_i & mhpmevent3_q);

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q        <= '0;
      minstret_q      <= '0;
      hpm3_q          <= '0;
      mhpmevent3_q    <= '0;
      mcountinhibit_q <= csr_pkg::MCOUNTINHIBIT_RESET_VAL;   // counters off
    end else begin
      mcycle_q   <= next_count(mcycle_q, cy_lo_we, cy_hi_we, cy_inc, csr_wdata_i);
      minstret_q <= next_count(minstret_q, ir_lo_we, ir_hi_we, ir_inc, csr_wdata_i);
      hpm3_q     <= next_count(hpm3_q, hpm_lo_we, hpm_hi_we, hpm_inc, csr_wdata_i);
      if (event_we) begin
        mhpmevent3_q <= csr_wdata_i[7:0];
      end
      if (inhibit_we) begin
        mcountinhibit_q <= csr_wdata_i & csr_pkg::MCOUNTINHIBIT_MASK;
      end
    end
  end

  assign mcycle_o        = mcycle_q;
  assign minstret_o      = minstret_q;
  assign mhpmcounter3_o  = hpm3_q;
  assign mhpmevent3_o    = {24'b0, mhpmevent3_q};   // upper selector bits read zero
  assign mcountinhibit_o = mcountinhibit_q;

endmodule

/* src/csr_pkg.sv */
////////////////////////////////////////
// csr package
// shared types, machine-mode CSR addresses,
// access operations, write masks and the
// reset values of the CSR block
////////////////////////////////////////

package csr_pkg;

  typedef logic [31:0] csr_data_t;    // one CSR value
  typedef logic [63:0] counter_t;     // full performance counter
  typedef logic [5:0]  cause_t;       // bit 5 interrupt, 4:0 code
  typedef logic [7:0]  hpm_event_t;   // event strobes, see below

  // hpm_event_t bit order
  // 0 load, 1 store, 2 jump, 3 branch, 4 branch taken,
  // 5 compressed, 6 load stall, 7 jump-register stall

  ////////////////////////////////////////
  // implemented CSR addresses
  ////////////////////////////////////////
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MHPMEVENT3    = 12'h323,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MHPMCOUNTER3  = 12'hB03,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHPMCOUNTER3H = 12'hB83,
    CSR_MVENDORID     = 12'hF11,
    CSR_MARCHID       = 12'hF12,
    CSR_MHARTID       = 12'hF14
  } csr_addr_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // writable mie bits: msie, mtie, meie and the platform range
  localparam csr_data_t IRQ_MASK = 32'hFFFF_0888;

  // rv32imc, mxl = 1
  localparam csr_data_t MISA_VALUE = (32'd1 << 30)   // mxl
                                   | (32'd1 << 12)   // m
                                   | (32'd1 << 8)    // i
                                   | (32'd1 << 2);   // c

  localparam csr_data_t MVENDORID_VALUE = 32'h0000_0000;
  localparam csr_data_t MARCHID_VALUE   = 32'h0000_0004;
  localparam csr_data_t HART_ID         = 32'h0000_0000;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  localparam csr_data_t MSTATUS_RESET_VAL       = 32'h0000_1800;  // mpp = machine
  localparam csr_data_t MTVEC_RESET_VAL         = 32'h0000_0001;  // vectored mode
  localparam csr_data_t MCOUNTINHIBIT_RESET_VAL = 32'h0000_000D;  // all counters off
  localparam csr_data_t MCOUNTINHIBIT_MASK      = 32'h0000_000D;  // cy, ir, hpm3

endpackage

/* src/csr_read_mux.sv */
////////////////////////////////////////
// CSR read multiplexer
// maps an address onto the value of the
// implemented CSR, zero for anything else
////////////////////////////////////////

module csr_read_mux (
  input  csr_pkg::csr_addr_e  addr_i,
  input  csr_pkg::csr_data_t  mstatus_i,
  input  csr_pkg::csr_data_t  mie_i,
  input  csr_pkg::csr_data_t  mtvec_i,
  input  csr_pkg::csr_data_t  mscratch_i,
  input  csr_pkg::csr_data_t  mepc_i,
  input  csr_pkg::csr_data_t  mcause_i,
  input  csr_pkg::csr_data_t  mcountinhibit_i,
  input  csr_pkg::csr_data_t  mhpmevent3_i,
  input  csr_pkg::counter_t   mcycle_i,
  input  csr_pkg::counter_t   minstret_i,
  input  csr_pkg::counter_t   mhpmcounter3_i,
  output csr_pkg::csr_data_t  data_o
);

  always_comb begin
    case (addr_i)
      csr_pkg::CSR_MSTATUS:       data_o = mstatus_i;
      csr_pkg::CSR_MIE:           data_o = mie_i;
      csr_pkg::CSR_MTVEC:         data_o = mtvec_i;
      csr_pkg::CSR_MSCRATCH:      data_o = mscratch_i;
      csr_pkg::CSR_MEPC:          data_o = mepc_i;
      csr_pkg::CSR_MCAUSE:        data_o = mcause_i;
      csr_pkg::CSR_MCOUNTINHIBIT: data_o = mcountinhibit_i;
      csr_pkg::CSR_MHPMEVENT3:    data_o = mhpmevent3_i;
      // counters, low halves
      csr_pkg::CSR_MCYCLE:        data_o = mcycle_i[31:0];
      csr_pkg::CSR_MINSTRET:      data_o = minstret_i[31:0];
      csr_pkg::CSR_MHPMCOUNTER3:  data_o = mhpmcounter3_i[31:0];
      // counters, high halves
      csr_pkg::CSR_MCYCLEH:       data_o = mcycle_i[63:32];
      csr_pkg::CSR_MINSTRETH:     data_o = minstret_i[63:32];
      csr_pkg::CSR_MHPMCOUNTER3H: data_o = mhpmcounter3_i[63:32];
      // identity, fixed at build time
      csr_pkg::CSR_MISA:          data_o = csr_pkg::MISA_VALUE;
      csr_pkg::CSR_MVENDORID:     data_o = csr_pkg::MVENDORID_VALUE;
      csr_pkg::CSR_MARCHID:       data_o = csr_pkg::MARCHID_VALUE;
      csr_pkg::CSR_MHARTID:       data_o = csr_pkg::HART_ID;
      default:                    data_o = '0;   // unimplemented
    endcase
  end

endmodule

/* src/csr_regfile.sv */
////////////////////////////////////////
// machine-mode CSR register file
// combinational read port, write/set/clear
// port, trap registers and counters
////////////////////////////////////////

module csr_regfile (
  input  logic                   clk,
  input  logic                   rst_n,

  // read port, execute stage
  input  csr_pkg::csr_addr_e     rd_addr_i,
  output csr_pkg::csr_data_t     rd_data_o,

  // write port, writeback stage
  input  logic                   wr_en_i,
  input  csr_pkg::csr_addr_e     wr_addr_i,
  input  csr_pkg::csr_op_e       wr_op_i,
  input  csr_pkg::csr_data_t     wr_data_i,

  // trap control from the controller
  input  logic                   trap_save_i,
  input  csr_pkg::cause_t        trap_cause_i,
  input  csr_pkg::csr_data_t     trap_pc_i,
  input  logic                   mret_i,

  // counter events
  input  logic                   retire_i,
  input  csr_pkg::hpm_event_t    hpm_event_i,

  output logic [23:0]            mtvec_addr_o,
  output logic [1:0]             mtvec_mode_o,
  output csr_pkg::csr_data_t     mepc_o,
  output csr_pkg::csr_data_t     mie_o,
  output logic                   m_irq_enable_o
);

  csr_pkg::csr_data_t mstatus;
  csr_pkg::csr_data_t mtvec;
  csr_pkg::csr_data_t mscratch;
  csr_pkg::csr_data_t mcause;
  csr_pkg::csr_data_t mcountinhibit;
  csr_pkg::csr_data_t mhpmevent3;
  csr_pkg::counter_t  mcycle;
  csr_pkg::counter_t  minstret;
  csr_pkg::counter_t  mhpmcounter3;

  csr_pkg::csr_data_t csr_wdata;   // legal-agnostic new value
  logic               csr_we;

  csr_read_mux u_rd_mux (
    .addr_i          (rd_addr_i),
    .mstatus_i       (mstatus),
    .mie_i           (mie_o),
    .mtvec_i         (mtvec),
    .mscratch_i      (mscratch),
    .mepc_i          (mepc_o),
    .mcause_i        (mcause),
    .mcountinhibit_i (mcountinhibit),
    .mhpmevent3_i    (mhpmevent3),
    .mcycle_i        (mcycle),
    .minstret_i      (minstret),
    .mhpmcounter3_i  (mhpmcounter3),
    .data_o          (rd_data_o)
  );

  csr_write_ctrl u_write_ctrl (
    .wr_en_i         (wr_en_i),
    .wr_addr_i       (wr_addr_i),
    .wr_op_i         (wr_op_i),
    .wr_data_i       (wr_data_i),
    .mstatus_i       (mstatus),
    .mie_i           (mie_o),
    .mtvec_i         (mtvec),
    .mscratch_i      (mscratch),
    .mepc_i          (mepc_o),
    .mcause_i        (mcause),
    .mcountinhibit_i (mcountinhibit),
    .mhpmevent3_i    (mhpmevent3),
    .mcycle_i        (mcycle),
    .minstret_i      (minstret),
    .mhpmcounter3_i  (mhpmcounter3),
    .csr_wdata_o     (csr_wdata),
    .csr_we_o        (csr_we)
  );

  csr_trap_regs u_trap_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_we_i       (csr_we),
    .csr_addr_i     (wr_addr_i),
    .csr_wdata_i    (csr_wdata),
    .trap_save_i    (trap_save_i),
    .trap_cause_i   (trap_cause_i),
    .trap_pc_i      (trap_pc_i),
    .mret_i         (mret_i),
    .mstatus_o      (mstatus),
    .mie_o          (mie_o),
    .mtvec_o        (mtvec),
    .mscratch_o     (mscratch),
    .mepc_o         (mepc_o),
    .mcause_o       (mcause),
    .mtvec_addr_o   (mtvec_addr_o),
    .mtvec_mode_o   (mtvec_mode_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  csr_perf_counters u_perf_counters (
    .clk             (clk),
    .rst_n           (rst_n),
    .csr_we_i        (csr_we),
    .csr_addr_i      (wr_addr_i),
    .csr_wdata_i     (csr_wdata),
    .retire_i        (retire_i),
    .hpm_event_i     (hpm_event_i),
    .mcycle_o        (mcycle),
    .minstret_o      (minstret),
    .mhpmcounter3_o  (mhpmcounter3),
    .mhpmevent3_o    (mhpmevent3),
    .mcountinhibit_o (mcountinhibit)
  );

endmodule

/* src/csr_trap_regs.sv */
////////////////////////////////////////
// machine trap CSRs
// mstatus, mie, mtvec, mscratch, mepc and
// mcause with write legalisation, trap
// entry and mret
////////////////////////////////////////

module csr_trap_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                csr_we_i,
  input  csr_pkg::csr_addr_e  csr_addr_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,
  input  logic                trap_save_i,
  input  csr_pkg::cause_t     trap_cause_i,
  input  csr_pkg::csr_data_t  trap_pc_i,
  input  logic                mret_i,
  output csr_pkg::csr_data_t  mstatus_o,
  output csr_pkg::csr_data_t  mie_o,
  output csr_pkg::csr_data_t  mtvec_o,
  output csr_pkg::csr_data_t  mscratch_o,
  output csr_pkg::csr_data_t  mepc_o,
  output csr_pkg::csr_data_t  mcause_o,
  output logic [23:0]         mtvec_addr_o,
  output logic [1:0]          mtvec_mode_o,
  output logic                m_irq_enable_o
);

  localparam int MIE  = csr_pkg::MSTATUS_MIE_BIT;
  localparam int MPIE = csr_pkg::MSTATUS_MPIE_BIT;

  csr_pkg::csr_data_t mstatus_q, mstatus_n;
  csr_pkg::csr_data_t mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q;

  logic mstatus_we, mie_we, mtvec_we, mscratch_we, mepc_we, mcause_we;

  // address decode, own registers only
  assign mstatus_we  = csr_we_i && (csr_addr_i == csr_pkg::CSR_MSTATUS);
  assign mie_we      = csr_we_i && (csr_addr_i == csr_pkg::CSR_MIE);
  assign mtvec_we    = csr_we_i && (csr_addr_i == csr_pkg::CSR_MTVEC);
  assign mscratch_we = csr_we_i && (csr_addr_i == csr_pkg::CSR_MSCRATCH);
  assign mepc_we     = csr_we_i && (csr_addr_i == csr_pkg::CSR_MEPC);
  assign mcause_we   = csr_we_i && (csr_addr_i == csr_pkg::CSR_MCAUSE);

  // trap entry first, then mret, then software
  always_comb begin
    mstatus_n = mstatus_q;
    if (trap_save_i) begin
      mstatus_n[MPIE] = mstatus_q[MIE];
      mstatus_n[MIE]  = 1'b0;
    end else if (mret_i) begin
      mstatus_n[MIE]  = mstatus_q[MPIE];
      mstatus_n[MPIE] = 1'b1;
    end else if (mstatus_we) begin
      mstatus_n       = csr_pkg::MSTATUS_RESET_VAL;   // mpp stays machine
      mstatus_n[MIE]  = csr_wdata_i[MIE];
      mstatus_n[MPIE] = csr_wdata_i[MPIE];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= csr_pkg::MSTATUS_RESET_VAL;
      mie_q      <= '0;
      mtvec_q    <= csr_pkg::MTVEC_RESET_VAL;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      mstatus_q <= mstatus_n;
      if (mie_we) mie_q <= csr_wdata_i & csr_pkg::IRQ_MASK;
      if (mtvec_we) mtvec_q <= {csr_wdata_i[31:8], 6'b0, 1'b0, csr_wdata_i[0]};
      if (mscratch_we) mscratch_q <= csr_wdata_i;
      if (trap_save_i) begin
        mepc_q   <= {trap_pc_i[31:1], 1'b0};
        mcause_q <= {trap_cause_i[5], 26'b0, trap_cause_i[4:0]};
      end else begin
        if (mepc_we) mepc_q <= {csr_wdata_i[31:1], 1'b0};
        if (mcause_we) mcause_q <= {csr_wdata_i[31], 26'b0, csr_wdata_i[4:0]};
      end
    end
  end

  assign mstatus_o  = mstatus_q;
  assign mie_o      = mie_q;
  assign mtvec_o    = mtvec_q;
  assign mscratch_o = mscratch_q;
  assign mepc_o     = mepc_q;
  assign mcause_o   = mcause_q;

  assign mtvec_addr_o   = mtvec_q[31:8];
  assign mtvec_mode_o   = mtvec_q[1:0];
  assign m_irq_enable_o = mstatus_q[MIE];   // global machine irq enable

endmodule

/* src/csr_write_ctrl.sv */
////////////////////////////////////////
// CSR write control
// builds the write, set or clear result
// from the value held at the write address
////////////////////////////////////////

module csr_write_ctrl (
  input  logic                wr_en_i,
  input  csr_pkg::csr_addr_e  wr_addr_i,
  input  csr_pkg::csr_op_e    wr_op_i,
  input  csr_pkg::csr_data_t  wr_data_i,
  input  csr_pkg::csr_data_t  mstatus_i,
  input  csr_pkg::csr_data_t  mie_i,
  input  csr_pkg::csr_data_t  mtvec_i,
  input  csr_pkg::csr_data_t  mscratch_i,
  input  csr_pkg::csr_data_t  mepc_i,
  input  csr_pkg::csr_data_t  mcause_i,
  input  csr_pkg::csr_data_t  mcountinhibit_i,
  input  csr_pkg::csr_data_t  mhpmevent3_i,
  input  csr_pkg::counter_t   mcycle_i,
  input  csr_pkg::counter_t   minstret_i,
  input  csr_pkg::counter_t   mhpmcounter3_i,
  output csr_pkg::csr_data_t  csr_wdata_o,
  output logic                csr_we_o
);

  csr_pkg::csr_data_t old_value;   // target before this edge

  csr_read_mux u_old_mux (
    .addr_i          (wr_addr_i),
    .mstatus_i       (mstatus_i),
    .mie_i           (mie_i),
    .mtvec_i         (mtvec_i),
    .mscratch_i      (mscratch_i),
    .mepc_i          (mepc_i),
    .mcause_i        (mcause_i),
    .mcountinhibit_i (mcountinhibit_i),
    .mhpmevent3_i    (mhpmevent3_i),
    .mcycle_i        (mcycle_i),
    .minstret_i      (minstret_i),
    .mhpmcounter3_i  (mhpmcounter3_i),
    .data_o          (old_value)
  );

  always_comb begin
    case (wr_op_i)
      csr_pkg::CSR_OP_WRITE: csr_wdata_o = wr_data_i;
      csr_pkg::CSR_OP_SET:   csr_wdata_o = old_value | wr_data_i;
      csr_pkg::CSR_OP_CLEAR: csr_wdata_o = old_value & ~wr_data_i;
      default:               csr_wdata_o = old_value;   // read keeps the value
    endcase
  end

  assign csr_we_o = wr_en_i && (wr_op_i != csr_pkg::CSR_OP_READ);

endmodule

/* tb.f */
src/csr_pkg.sv
src/csr_read_mux.sv
src/csr_write_ctrl.sv
src/csr_trap_regs.sv
src/csr_perf_counters.sv
src/csr_regfile.sv
verif/csr_checker.sv
verif/tb_csr_regfile.sv

/* verif/csr_checker.sv */
////////////////////////////////////////
// CSR output checker
// concurrent properties on the outputs
// of the CSR register file
////////////////////////////////////////

module csr_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                trap_save_i,
  input csr_pkg::csr_data_t  mepc_i,
  input logic [1:0]          mtvec_mode_i,
  input csr_pkg::csr_data_t  mie_i,
  input logic                m_irq_enable_i
);

  a_mepc_aligned: assert property (@(posedge clk) disable iff (!rst_n) !mepc_i[0])
    else $error("mepc has bit 0 set");

  a_mtvec_mode: assert property (@(posedge clk) disable iff (!rst_n) !mtvec_mode_i[1])
    else $error("mtvec mode has bit 1 set");

  // only the writable interrupt enables may be set
  a_mie_legal: assert property (@(posedge clk) disable iff (!rst_n)
                                (mie_i & ~csr_pkg::IRQ_MASK) == 32'h0)
    else $error("mie has bits outside the writable mask");

  a_trap_disables_irq: assert property (@(posedge clk) disable iff (!rst_n)
                                        trap_save_i |=> !m_irq_enable_i)
    else $error("interrupts still enabled one cycle after trap entry");

endmodule

bind csr_regfile csr_checker u_csr_checker (
  .clk            (clk),
  .rst_n          (rst_n),
  .trap_save_i    (trap_save_i),
  .mepc_i         (mepc_o),
  .mtvec_mode_i   (mtvec_mode_o),
  .mie_i          (mie_o),
  .m_irq_enable_i (m_irq_enable_o)
);

/* verif/tb_csr_regfile.sv */
////////////////////////////////////////
// testbench for the CSR register file
// seeded random stimulus checked against
// a reference model of the CSR rules
////////////////////////////////////////

module tb_csr_regfile;

  localparam int RESET_CYCLES = 10;
  localparam int N_TRAP_RW    = 300;
  localparam int N_TRAP_MIX   = 300;
  localparam int N_COUNT      = 400;
  // reset test takes 22 cycles, the mcycle test stays under 80
  localparam int RUN_CYCLES   = RESET_CYCLES + 22 + N_TRAP_RW + N_TRAP_MIX + 80 + N_COUNT;
  localparam int TIMEOUT      = (RUN_CYCLES + 200) * 8;

  logic clk = 1'b0;
  logic rst_n;
  csr_pkg::csr_addr_e  rd_addr_i, wr_addr_i;
  csr_pkg::csr_op_e    wr_op_i;
  csr_pkg::csr_data_t  wr_data_i, trap_pc_i, rd_data_o, mepc_o, mie_o;
  csr_pkg::cause_t     trap_cause_i;
  csr_pkg::hpm_event_t hpm_event_i;
  logic                wr_en_i, trap_save_i, mret_i, retire_i, m_irq_enable_o;
  logic [23:0]         mtvec_addr_o;
  logic [1:0]          mtvec_mode_o;

  // reference model state
  csr_pkg::csr_data_t m_mstatus, m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause;
  csr_pkg::csr_data_t m_inhibit, m_event;
  csr_pkg::counter_t  m_cycle, m_instret, m_hpm;

  int check_count = 0;
  int error_count = 0;
  int last_checks = 0;
  int last_errors = 0;

  always #4 clk = ~clk;

  csr_regfile u_csr_regfile (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_addr_i      (rd_addr_i),
    .rd_data_o      (rd_data_o),
    .wr_en_i        (wr_en_i),
    .wr_addr_i      (wr_addr_i),
    .wr_op_i        (wr_op_i),
    .wr_data_i      (wr_data_i),
    .trap_save_i    (trap_save_i),
    .trap_cause_i   (trap_cause_i),
    .trap_pc_i      (trap_pc_i),
    .mret_i         (mret_i),
    .retire_i       (retire_i),
    .hpm_event_i    (hpm_event_i),
    .mtvec_addr_o   (mtvec_addr_o),
    .mtvec_mode_o   (mtvec_mode_o),
    .mepc_o         (mepc_o),
    .mie_o          (mie_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  ////////////////////////////////////////
  // address list and random helpers
  ////////////////////////////////////////
  function automatic logic [11:0] csr_addr_at(input int idx);
    case (idx)
      0:  return csr_pkg::CSR_MSTATUS;   // 0..5 trap registers
      1:  return csr_pkg::CSR_MIE;
      2:  return csr_pkg::CSR_MTVEC;
      3:  return csr_pkg::CSR_MSCRATCH;
      4:  return csr_pkg::CSR_MEPC;
      5:  return csr_pkg::CSR_MCAUSE;
      6:  return csr_pkg::CSR_MCOUNTINHIBIT;
      7:  return csr_pkg::CSR_MHPMEVENT3;
      8:  return csr_pkg::CSR_MCYCLE;
      9:  return csr_pkg::CSR_MCYCLEH;
      10: return csr_pkg::CSR_MINSTRET;    // 10..13 event counter halves
      11: return csr_pkg::CSR_MINSTRETH;
      12: return csr_pkg::CSR_MHPMCOUNTER3;
      13: return csr_pkg::CSR_MHPMCOUNTER3H;
      14: return csr_pkg::CSR_MISA;
      15: return csr_pkg::CSR_MVENDORID;
      16: return csr_pkg::CSR_MARCHID;
      17: return csr_pkg::CSR_MHARTID;
      18: return 12'h344;   // mip, not implemented
      19: return 12'h7B0;   // dcsr, not implemented
      20: return 12'hC00;
      default: return 12'h7C0;
    endcase
  endfunction

  function automatic csr_pkg::csr_data_t rand_data();
    csr_pkg::csr_data_t r;
    r = $urandom;
    return r;
  endfunction

  function automatic csr_pkg::csr_op_e rand_op();
    csr_pkg::csr_data_t r;
    r = $urandom;
    return csr_pkg::csr_op_e'(r[1:0]);
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic csr_pkg::csr_data_t model_read(input logic [11:0] addr);
    case (addr)
      csr_pkg::CSR_MSTATUS:       return m_mstatus;
      csr_pkg::CSR_MIE:           return m_mie;
      csr_pkg::CSR_MTVEC:         return m_mtvec;
      csr_pkg::CSR_MSCRATCH:      return m_mscratch;
      csr_pkg::CSR_MEPC:          return m_mepc;
      csr_pkg::CSR_MCAUSE:        return m_mcause;
      csr_pkg::CSR_MCOUNTINHIBIT: return m_inhibit;
      csr_pkg::CSR_MHPMEVENT3:    return m_event;
      csr_pkg::CSR_MCYCLE:        return m_cycle[31:0];
      csr_pkg::CSR_MCYCLEH:       return m_cycle[63:32];
      csr_pkg::CSR_MINSTRET:      return m_instret[31:0];
      csr_pkg::CSR_MINSTRETH:     return m_instret[63:32];
      csr_pkg::CSR_MHPMCOUNTER3:  return m_hpm[31:0];
      csr_pkg::CSR_MHPMCOUNTER3H: return m_hpm[63:32];
      csr_pkg::CSR_MISA:          return csr_pkg::MISA_VALUE;
      csr_pkg::CSR_MVENDORID:     return csr_pkg::MVENDORID_VALUE;
      csr_pkg::CSR_MARCHID:       return csr_pkg::MARCHID_VALUE;
      csr_pkg::CSR_MHARTID:       return csr_pkg::HART_ID;
      default:                    return 32'h0;
    endcase
  endfunction

  task automatic model_reset();
    m_mstatus  = csr_pkg::MSTATUS_RESET_VAL;
    m_mtvec    = csr_pkg::MTVEC_RESET_VAL;
    m_inhibit  = csr_pkg::MCOUNTINHIBIT_RESET_VAL;
    m_mie      = '0;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_event    = '0;
    m_cycle    = '0;
    m_instret  = '0;
    m_hpm      = '0;
  endtask

  // state after the coming edge, from the inputs driven this cycle
  task automatic model_apply();
    csr_pkg::csr_data_t old_val, new_val;
    logic [11:0] a;
    logic we, cy_inc, ir_inc, hpm_inc;
    a       = wr_addr_i;
    old_val = model_read(a);
    case (wr_op_i)
      csr_pkg::CSR_OP_WRITE: new_val = wr_data_i;
      csr_pkg::CSR_OP_SET:   new_val = old_val | wr_data_i;
      csr_pkg::CSR_OP_CLEAR: new_val = old_val & ~wr_data_i;
      default:               new_val = old_val;
    endcase
    we      = wr_en_i && (wr_op_i != csr_pkg::CSR_OP_READ);
    cy_inc  = !m_inhibit[0];
    ir_inc  = !m_inhibit[2] && retire_i;
    hpm_inc = !m_inhibit[3] && (|(hpm_event_i & m_event[7:0]));
    if (trap_save_i) begin   // trap entry beats mret and software
      m_mstatus[7] = m_mstatus[3];
      m_mstatus[3] = 1'b0;
      m_mepc       = {trap_pc_i[31:1], 1'b0};
      m_mcause     = {trap_cause_i[5], 26'b0, trap_cause_i[4:0]};
    end else begin
      if (mret_i) begin
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
      end else if (we && a == csr_pkg::CSR_MSTATUS) begin
        m_mstatus = csr_pkg::MSTATUS_RESET_VAL | (new_val & 32'h0000_0088);
      end
      if (we && a == csr_pkg::CSR_MEPC) m_mepc = new_val & 32'hFFFF_FFFE;
      if (we && a == csr_pkg::CSR_MCAUSE) m_mcause = new_val & 32'h8000_001F;
    end
    if (we) begin
      case (a)
        csr_pkg::CSR_MIE:           m_mie = new_val & csr_pkg::IRQ_MASK;
        csr_pkg::CSR_MTVEC:         m_mtvec = {new_val[31:8], 7'b0, new_val[0]};
        csr_pkg::CSR_MSCRATCH:      m_mscratch = new_val;
        csr_pkg::CSR_MHPMEVENT3:    m_event = {24'b0, new_val[7:0]};
        csr_pkg::CSR_MCOUNTINHIBIT: m_inhibit = new_val & 32'h0000_000D;
        default: ;
      endcase
    end
    // a half write takes the place of the increment
    if (we && a == csr_pkg::CSR_MCYCLE) m_cycle[31:0] = new_val;
    else if (we && a == csr_pkg::CSR_MCYCLEH) m_cycle[63:32] = new_val;
    else if (cy_inc) m_cycle = m_cycle + 64'd1;
    if (we && a == csr_pkg::CSR_MINSTRET) m_instret[31:0] = new_val;
    else if (we && a == csr_pkg::CSR_MINSTRETH) m_instret[63:32] = new_val;
    else if (ir_inc) m_instret = m_instret + 64'd1;
    if (we && a == csr_pkg::CSR_MHPMCOUNTER3) m_hpm[31:0] = new_val;
    else if (we && a == csr_pkg::CSR_MHPMCOUNTER3H) m_hpm[63:32] = new_val;
    else if (hpm_inc) m_hpm = m_hpm + 64'd1;
  endtask

  ////////////////////////////////////////
  // checks and stimulus
  ////////////////////////////////////////
  task automatic check_value(input string what, input csr_pkg::csr_data_t got,
                             input csr_pkg::csr_data_t exp);
    check_count++;
    assert (got === exp) else begin
      $display("FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_outputs();
    check_value($sformatf("rd_data at %h", rd_addr_i), rd_data_o, model_read(rd_addr_i));
    check_value("mie_o", mie_o, m_mie);
    check_value("mepc_o", mepc_o, m_mepc);
    check_value("mtvec outputs", {mtvec_addr_o, 6'b0, mtvec_mode_o}, m_mtvec);
    check_value("m_irq_enable_o", {31'b0, m_irq_enable_o}, {31'b0, m_mstatus[3]});
  endtask

  // drive at the rising edge, check and step the model at the falling edge
  task automatic drive_cycle(input logic we, input logic [11:0] waddr,
                             input csr_pkg::csr_op_e op, input csr_pkg::csr_data_t wdata,
                             input logic [11:0] raddr, input logic trap, input logic mret,
                             input logic retire, input csr_pkg::hpm_event_t ev);
    csr_pkg::csr_data_t r;
    r = $urandom;
    @(posedge clk);
    wr_en_i      <= we;
    wr_addr_i    <= csr_pkg::csr_addr_e'(waddr);
    wr_op_i      <= op;
    wr_data_i    <= wdata;
    rd_addr_i    <= csr_pkg::csr_addr_e'(raddr);
    trap_save_i  <= trap;
    trap_cause_i <= r[5:0];
    trap_pc_i    <= rand_data();
    mret_i       <= mret;
    retire_i     <= retire;
    hpm_event_i  <= ev;
    @(negedge clk);
    check_outputs();
    model_apply();
  endtask

  task automatic idle_read(input logic [11:0] raddr);
    drive_cycle(1'b0, raddr, csr_pkg::CSR_OP_READ, 32'h0, raddr, 1'b0, 1'b0, 1'b0, 8'h0);
  endtask

  task automatic finish_test(input string name);
    $display("test %s done: %0d checks, %0d errors", name,
             check_count - last_checks, error_count - last_errors);
    last_checks = check_count;
    last_errors = error_count;
  endtask

  initial begin
    #(TIMEOUT);
    $display("watchdog: the run did not finish within %0d time units", TIMEOUT);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    csr_pkg::csr_data_t r, v1, v2;
    int idx, prev_idx, gap;
    void'($urandom(44921));
    rst_n        = 1'b0;
    wr_en_i      = 1'b0;
    wr_addr_i    = csr_pkg::CSR_MSTATUS;
    wr_op_i      = csr_pkg::CSR_OP_READ;
    wr_data_i    = '0;
    rd_addr_i    = csr_pkg::CSR_MSTATUS;
    trap_save_i  = 1'b0;
    trap_cause_i = '0;
    trap_pc_i    = '0;
    mret_i       = 1'b0;
    retire_i     = 1'b0;
    hpm_event_i  = '0;
    prev_idx     = 0;
    model_reset();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < 22; i++) idle_read(csr_addr_at(i));
    finish_test("reset_values");

    for (int n = 0; n < N_TRAP_RW; n++) begin
      r   = $urandom;
      idx = $urandom_range(5, 0);
      drive_cycle(r[2:0] != 3'b000, csr_addr_at(idx), rand_op(), rand_data(),
                  csr_addr_at(r[3] ? prev_idx : int'($urandom_range(5, 0))),
                  1'b0, 1'b0, 1'b0, 8'h0);
      prev_idx = idx;
    end
    finish_test("trap_register_access");

    for (int n = 0; n < N_TRAP_MIX; n++) begin
      r = $urandom;   // trap and mret never together
      drive_cycle(r[4], csr_addr_at($urandom_range(5, 0)), rand_op(), rand_data(),
                  csr_addr_at($urandom_range(5, 0)), r[1:0] == 2'b00,
                  r[1:0] != 2'b00 && r[3:2] == 2'b00, 1'b0, 8'h0);
    end
    finish_test("trap_entry_mret");

    drive_cycle(1'b1, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_OP_CLEAR, 32'h1,
                csr_pkg::CSR_MCYCLE, 1'b0, 1'b0, 1'b0, 8'h0);
    idle_read(csr_pkg::CSR_MCYCLE);
    v1  = rd_data_o;
    gap = $urandom_range(24, 5);
    repeat (gap) idle_read(csr_pkg::CSR_MCYCLE);
    v2 = rd_data_o;
    check_value("mcycle delta", v2 - v1, csr_pkg::csr_data_t'(gap));
    drive_cycle(1'b1, csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_OP_WRITE, rand_data(),
                csr_pkg::CSR_MCYCLEH, 1'b0, 1'b0, 1'b0, 8'h0);
    drive_cycle(1'b1, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_OP_WRITE, 32'hFFFF_FFF8,
                csr_pkg::CSR_MCYCLE, 1'b0, 1'b0, 1'b0, 8'h0);
    repeat (16) idle_read(csr_pkg::CSR_MCYCLEH);   // carry into the high half
    drive_cycle(1'b1, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_OP_SET, 32'h1,
                csr_pkg::CSR_MCYCLE, 1'b0, 1'b0, 1'b0, 8'h0);
    idle_read(csr_pkg::CSR_MCYCLE);
    v1 = rd_data_o;
    repeat (gap) idle_read(csr_pkg::CSR_MCYCLE);
    check_value("inhibited mcycle", rd_data_o, v1);
    finish_test("mcycle");

    for (int n = 0; n < N_COUNT; n++) begin
      r = $urandom;
      if (n % 50 == 0) begin   // new selector every window
        drive_cycle(1'b1, csr_pkg::CSR_MHPMEVENT3, csr_pkg::CSR_OP_WRITE, rand_data(),
                    csr_addr_at(10 + n % 4), 1'b0, 1'b0, r[8], r[23:16]);
      end else if (n % 50 == 1) begin
        drive_cycle(1'b1, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_OP_WRITE,
                    n < 50 ? 32'h0 : rand_data(), csr_addr_at(10 + n % 4),
                    1'b0, 1'b0, r[8], r[23:16]);
      end else begin
        drive_cycle(1'b0, csr_addr_at($urandom_range(13, 10)), rand_op(), rand_data(),
                    csr_addr_at(10 + n % 4), 1'b0, 1'b0, r[8], r[23:16]);
      end
    end
    finish_test("event_counters");

    $display("summary: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
